/* verilog/f8_isa_pkg.sv */
`default_nettype none

package f8_isa_pkg;

	typedef logic [7:0] opcode_t;
	// opcode byte, then up to two operand bytes
	typedef logic [23:0] inst_t;
	typedef logic [1:0] len_t;

	localparam opcode_t OPCODE_TRAP        = 8'h00;
	localparam opcode_t OPCODE_NOP         = 8'h08;
	// 8-bit ops on xl; the direct form sits at the odd opcode
	localparam opcode_t OPCODE_SUB_XL_IMMD = 8'h10;
	localparam opcode_t OPCODE_SUB_XL_DIR  = 8'h11;
	localparam opcode_t OPCODE_SBC_XL_IMMD = 8'h18;
	localparam opcode_t OPCODE_SBC_XL_DIR  = 8'h19;
	localparam opcode_t OPCODE_ADD_XL_IMMD = 8'h20;
	localparam opcode_t OPCODE_ADD_XL_DIR  = 8'h21;
	localparam opcode_t OPCODE_ADC_XL_IMMD = 8'h28;
	localparam opcode_t OPCODE_ADC_XL_DIR  = 8'h29;
	localparam opcode_t OPCODE_OR_XL_IMMD  = 8'h38;
	localparam opcode_t OPCODE_OR_XL_DIR   = 8'h39;
	localparam opcode_t OPCODE_AND_XL_IMMD = 8'h40;
	localparam opcode_t OPCODE_AND_XL_DIR  = 8'h41;
	localparam opcode_t OPCODE_XOR_XL_IMMD = 8'h48;
	localparam opcode_t OPCODE_XOR_XL_DIR  = 8'h49;
	localparam opcode_t OPCODE_ADDW_Y_IMMD = 8'h50;
	localparam opcode_t OPCODE_JP_IMMD     = 8'h64;
	localparam opcode_t OPCODE_JP_Y        = 8'h65;
	localparam opcode_t OPCODE_JR_D        = 8'h66;
	localparam opcode_t OPCODE_JRZ_D       = 8'h67;
	localparam opcode_t OPCODE_JRNZ_D      = 8'h68;
	localparam opcode_t OPCODE_JRC_D       = 8'h69;
	localparam opcode_t OPCODE_JRNC_D      = 8'h6a;
	localparam opcode_t OPCODE_INCW_Y      = 8'h70;
	localparam opcode_t OPCODE_LD_XL_IMMD  = 8'h90;
	localparam opcode_t OPCODE_LD_XL_DIR   = 8'h91;
	localparam opcode_t OPCODE_LD_DIR_XL   = 8'h99;
	localparam opcode_t OPCODE_LD_XL_IY    = 8'h9d;
	localparam opcode_t OPCODE_LDW_Y_IMMD  = 8'ha0;
	localparam opcode_t OPCODE_LDW_DIR_Y   = 8'ha9;
	localparam opcode_t OPCODE_LDW_X_Y     = 8'hb0;
	localparam opcode_t OPCODE_LDW_Z_Y     = 8'hb1;
	localparam opcode_t OPCODE_LDW_Y_Z     = 8'hb2;

	typedef enum logic [3:0] {
		PASS, ADD, ADC, SUB, SBC, AND, OR, XOR, ADDW, PASSW
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NONE, BR_JP_IMMD, BR_JP_Y, BR_JR, BR_JRZ, BR_JRNZ, BR_JRC, BR_JRNC
	} branch_t;

	typedef enum logic [1:0] {
		RD_NONE, RD_DIRECT, RD_IY
	} read_mode_t;

endpackage

`default_nettype wire

/* verilog/f8_core_pkg.sv */
`default_nettype none

package f8_core_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0] flags_t;
	typedef logic [1:0] byte_en_t;

	localparam int FLAG_C = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_Z = 3;
	localparam int FLAG_O = 4;

	typedef enum logic [1:0] {
		REG_X = 2'd0,
		REG_Y = 2'd1,
		REG_Z = 2'd2
	} reg_idx_t;

	// accumulator is xl
	typedef enum logic [1:0] {
		SRC_A_ACC, SRC_A_Y, SRC_A_Z, SRC_A_X
	} src_a_t;

	typedef enum logic [1:0] {
		SRC_B_IMM, SRC_B_MEM
	} src_b_t;

endpackage

`default_nettype wire

/* verilog/f8_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module f8_decode
	import f8_core_pkg::*, f8_isa_pkg::*;
(
	input logic clk,
	input logic reset,
	input inst_t fetch_inst,
	output len_t fetch_len,
	output branch_t fetch_branch,
	output read_mode_t fetch_read_mode,
	output alu_op_t exec_op,
	output src_a_t exec_src_a,
	output src_b_t exec_src_b,
	output logic exec_wide,
	output reg_idx_t exec_dest,
	output byte_en_t exec_reg_en,
	output byte_en_t exec_store,
	output word_t exec_imm,
	output logic exec_trap
);

	alu_op_t n_op;
	src_a_t n_src_a;
	src_b_t n_src_b;
	logic n_wide;
	reg_idx_t n_dest;
	byte_en_t n_reg_en;
	byte_en_t n_store;
	word_t n_imm;
	logic n_trap;
	logic alu8;

	always_comb
	begin
		n_op = PASS;
		n_src_a = SRC_A_ACC;
		n_src_b = SRC_B_IMM;
		n_wide = 1'b0;
		n_dest = REG_X;
		n_reg_en = 2'b00;
		n_store = 2'b00;
		n_imm = fetch_inst[23:8];
		n_trap = 1'b0;
		fetch_len = 2'd1;
		fetch_branch = BR_NONE;
		fetch_read_mode = RD_NONE;
		alu8 = 1'b1;

		case (fetch_inst[7:0])
			OPCODE_LD_XL_IMMD, OPCODE_LD_XL_DIR: n_op = PASS;
			OPCODE_ADD_XL_IMMD, OPCODE_ADD_XL_DIR: n_op = ADD;
			OPCODE_ADC_XL_IMMD, OPCODE_ADC_XL_DIR: n_op = ADC;
			OPCODE_SUB_XL_IMMD, OPCODE_SUB_XL_DIR: n_op = SUB;
			OPCODE_SBC_XL_IMMD, OPCODE_SBC_XL_DIR: n_op = SBC;
			OPCODE_AND_XL_IMMD, OPCODE_AND_XL_DIR: n_op = AND;
			OPCODE_OR_XL_IMMD, OPCODE_OR_XL_DIR: n_op = OR;
			OPCODE_XOR_XL_IMMD, OPCODE_XOR_XL_DIR: n_op = XOR;
			default: alu8 = 1'b0;
		endcase

		if (alu8)
		begin
			n_reg_en = 2'b01;
			fetch_len = 2'd2;
			// odd opcode takes its operand from memory
			if (fetch_inst[0])
			begin
				n_src_b = SRC_B_MEM;
				fetch_len = 2'd3;
				fetch_read_mode = RD_DIRECT;
			end
		end

		case (fetch_inst[7:0])
			OPCODE_TRAP: n_trap = 1'b1;
			OPCODE_LD_DIR_XL:
			begin
				n_op = PASSW;
				n_store = 2'b01;
				fetch_len = 2'd3;
			end
			OPCODE_LD_XL_IY:
			begin
				n_src_b = SRC_B_MEM;
				n_reg_en = 2'b01;
				fetch_read_mode = RD_IY;
			end
			OPCODE_LDW_Y_IMMD, OPCODE_ADDW_Y_IMMD, OPCODE_INCW_Y:
			begin
				n_op = (fetch_inst[7:0] == OPCODE_LDW_Y_IMMD) ? PASS : ADDW;
				n_src_a = SRC_A_Y;
				n_wide = 1'b1;
				n_dest = REG_Y;
				n_reg_en = 2'b11;
				fetch_len = (fetch_inst[7:0] == OPCODE_INCW_Y) ? 2'd1 : 2'd3;
				if (fetch_inst[7:0] == OPCODE_INCW_Y)
					n_imm = 16'h0001;
			end
			OPCODE_LDW_DIR_Y, OPCODE_LDW_X_Y, OPCODE_LDW_Z_Y, OPCODE_LDW_Y_Z:
			begin
				n_op = PASSW;
				n_wide = 1'b1;
				n_src_a = (fetch_inst[7:0] == OPCODE_LDW_Y_Z) ? SRC_A_Z : SRC_A_Y;
				n_dest = (fetch_inst[7:0] == OPCODE_LDW_X_Y) ? REG_X :
					(fetch_inst[7:0] == OPCODE_LDW_Z_Y) ? REG_Z : REG_Y;
				n_reg_en = (fetch_inst[7:0] == OPCODE_LDW_DIR_Y) ? 2'b00 : 2'b11;
				n_store = (fetch_inst[7:0] == OPCODE_LDW_DIR_Y) ? 2'b11 : 2'b00;
				fetch_len = (fetch_inst[7:0] == OPCODE_LDW_DIR_Y) ? 2'd3 : 2'd1;
			end
			OPCODE_JP_IMMD:
			begin
				fetch_branch = BR_JP_IMMD;
				fetch_len = 2'd3;
			end
			OPCODE_JP_Y: fetch_branch = BR_JP_Y;
			OPCODE_JR_D, OPCODE_JRZ_D, OPCODE_JRNZ_D, OPCODE_JRC_D, OPCODE_JRNC_D:
			begin
				fetch_len = 2'd2;
				fetch_branch = (fetch_inst[7:0] == OPCODE_JRZ_D) ? BR_JRZ :
					(fetch_inst[7:0] == OPCODE_JRNZ_D) ? BR_JRNZ :
					(fetch_inst[7:0] == OPCODE_JRC_D) ? BR_JRC :
					(fetch_inst[7:0] == OPCODE_JRNC_D) ? BR_JRNC : BR_JR;
			end
			default: ;
		endcase
	end

	// reset state is a nop
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			exec_op <= PASS;
			exec_src_a <= SRC_A_ACC;
			exec_src_b <= SRC_B_IMM;
			exec_wide <= 1'b0;
			exec_dest <= REG_X;
			exec_reg_en <= 2'b00;
			exec_store <= 2'b00;
			exec_trap <= 1'b0;
		end
		else
		begin
			exec_op <= n_op;
			exec_src_a <= n_src_a;
			exec_src_b <= n_src_b;
			exec_wide <= n_wide;
			exec_dest <= n_dest;
			exec_reg_en <= n_reg_en;
			exec_store <= n_store;
			exec_trap <= n_trap;
		end
	end

	always_ff @(posedge clk)
		exec_imm <= n_imm;

endmodule

`default_nettype wire

/* verilog/f8_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module f8_fetch
	import f8_core_pkg::*, f8_isa_pkg::*;
#(
	parameter word_t RESET_PC = 16'h4000
)
(
	input logic clk,
	input logic reset,
	input inst_t fetch_inst,
	input len_t fetch_len,
	input branch_t fetch_branch,
	input read_mode_t fetch_read_mode,
	input word_t next_y,
	input flags_t next_flags,
	output word_t iread_addr,
	output word_t dread_addr
);

	// address of the instruction whose fetch word is arriving
	word_t pc;
	word_t next_pc;
	logic taken;

	always_comb
	begin
		case (fetch_branch)
			BR_JR: taken = 1'b1;
			BR_JRZ: taken = next_flags[FLAG_Z];
			BR_JRNZ: taken = !next_flags[FLAG_Z];
			BR_JRC: taken = next_flags[FLAG_C];
			BR_JRNC: taken = !next_flags[FLAG_C];
			default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset)
			next_pc = RESET_PC;
		else if (fetch_branch == BR_JP_IMMD)
			next_pc = fetch_inst[23:8];
		else if (fetch_branch == BR_JP_Y)
			next_pc = next_y;
		else if (taken)
			next_pc = pc + {{8{fetch_inst[15]}}, fetch_inst[15:8]};
		else
			next_pc = pc + {14'd0, fetch_len};
	end

	always_ff @(posedge clk)
		pc <= next_pc;

	assign iread_addr = next_pc;

	// y may be written by the instruction executing now
	assign dread_addr = (fetch_read_mode == RD_IY) ? next_y : fetch_inst[23:8];

endmodule

`default_nettype wire

/* verilog/f8_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module f8_regfile
	import f8_core_pkg::*;
(
	input logic clk,
	input reg_idx_t write_idx,
	input byte_en_t write_en,
	input word_t write_data,
	output word_t x,
	output word_t y,
	output word_t z,
	output word_t next_x,
	output word_t next_y,
	output word_t next_z
);

	// register value after this cycle's byte writes
	function automatic word_t merge(input word_t cur, input reg_idx_t idx);
		word_t v;
		v = cur;
		if (write_idx == idx && write_en[0])
			v[7:0] = write_data[7:0];
		if (write_idx == idx && write_en[1])
			v[15:8] = write_data[15:8];
		return v;
	endfunction

	assign next_x = merge(x, REG_X);
	assign next_y = merge(y, REG_Y);
	assign next_z = merge(z, REG_Z);

	always_ff @(posedge clk)
	begin
		x <= next_x;
		y <= next_y;
		z <= next_z;
	end

endmodule

`default_nettype wire

/* verilog/f8_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module f8_execute
	import f8_core_pkg::*, f8_isa_pkg::*;
(
	input alu_op_t exec_op,
	input src_a_t exec_src_a,
	input src_b_t exec_src_b,
	input logic exec_wide,
	input word_t exec_imm,
	input word_t x,
	input word_t y,
	input word_t z,
	input word_t dread_data,
	input flags_t flags,
	output word_t result,
	output flags_t alu_flags
);

	word_t a;
	word_t b;
	word_t b_in;
	byte_t a_lo;
	byte_t b_lo;
	logic cin;
	logic [8:0] sum8;
	logic [16:0] sum16;
	logic carry;
	logic ovf;

	always_comb
	begin
		case (exec_src_a)
			SRC_A_Y: a = y;
			SRC_A_Z: a = z;
			SRC_A_X: a = x;
			default: a = {8'h00, x[7:0]};
		endcase
	end

	assign b = (exec_src_b == SRC_B_MEM) ? dread_data : exec_imm;

	// subtract as a + ~b + 1, sbc uses c for the final one
	assign b_in = (exec_op == SUB || exec_op == SBC) ? ~b : b;

	always_comb
	begin
		case (exec_op)
			SUB: cin = 1'b1;
			ADC, SBC: cin = flags[FLAG_C];
			default: cin = 1'b0;
		endcase
	end

	assign a_lo = a[7:0];
	assign b_lo = b_in[7:0];
	assign sum8 = {1'b0, a_lo} + {1'b0, b_lo} + {8'd0, cin};
	assign sum16 = {1'b0, a} + {1'b0, b_in} + {16'd0, cin};

	always_comb
	begin
		carry = 1'b0;
		ovf = 1'b0;
		case (exec_op)
			ADD, ADC, SUB, SBC:
			begin
				result = {8'h00, sum8[7:0]};
				carry = sum8[8];
				ovf = (a_lo[7] == b_lo[7]) && (sum8[7] != a_lo[7]);
			end
			ADDW:
			begin
				result = sum16[15:0];
				carry = sum16[16];
				ovf = (a[15] == b_in[15]) && (sum16[15] != a[15]);
			end
			AND: result = {8'h00, a_lo & b[7:0]};
			OR: result = {8'h00, a_lo | b[7:0]};
			XOR: result = {8'h00, a_lo ^ b[7:0]};
			PASSW: result = a;
			default: result = exec_wide ? b : {8'h00, b[7:0]};
		endcase
	end

	always_comb
	begin
		alu_flags = '0;
		alu_flags[FLAG_C] = carry;
		alu_flags[FLAG_O] = ovf;
		alu_flags[FLAG_N] = exec_wide ? result[15] : result[7];
		alu_flags[FLAG_Z] = exec_wide ? (result == 16'h0000) : (result[7:0] == 8'h00);
	end

endmodule

`default_nettype wire

/* verilog/f8_result.sv */
`timescale 1ns/1ps
`default_nettype none

module f8_result
	import f8_core_pkg::*, f8_isa_pkg::*;
(
	input logic clk,
	input logic reset,
	input alu_op_t exec_op,
	input logic exec_wide,
	input reg_idx_t exec_dest,
	input byte_en_t exec_reg_en,
	input byte_en_t exec_store,
	input word_t exec_imm,
	input logic exec_trap,
	input word_t result,
	input flags_t alu_flags,
	output flags_t flags,
	output flags_t next_flags,
	output reg_idx_t write_idx,
	output byte_en_t write_en,
	output word_t write_data,
	output word_t dwrite_addr,
	output word_t dwrite_data,
	output byte_en_t dwrite_en,
	output logic trap
);

	logic upd_arith;
	logic upd_logic;

	assign upd_arith = exec_op inside {ADD, ADC, SUB, SBC, ADDW};
	assign upd_logic = upd_arith || exec_op inside {AND, OR, XOR};

	// logic ops touch only n and z
	always_comb
	begin
		next_flags = flags;
		if (upd_logic)
		begin
			next_flags[FLAG_N] = alu_flags[FLAG_N];
			next_flags[FLAG_Z] = alu_flags[FLAG_Z];
		end
		if (upd_arith)
		begin
			next_flags[FLAG_C] = alu_flags[FLAG_C];
			next_flags[FLAG_O] = alu_flags[FLAG_O];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	assign write_idx = exec_dest;
	assign write_en = exec_reg_en;
	assign write_data = result;

	// byte stores carry xl in the low byte only
	assign dwrite_addr = exec_imm;
	assign dwrite_data = exec_wide ? result : {8'h00, result[7:0]};
	assign dwrite_en = reset ? 2'b00 : exec_store;
	assign trap = !reset && exec_trap;

endmodule

`default_nettype wire

/* verilog/f8_core.sv */
`timescale 1ns/1ps
`default_nettype none

module f8_core
	import f8_core_pkg::*, f8_isa_pkg::*;
#(
	parameter word_t RESET_PC = 16'h4000
)
(
	input logic clk,
	input logic reset,
	output word_t iread_addr,
	input inst_t iread_data,
	output word_t dread_addr,
	input word_t dread_data,
	output word_t dwrite_addr,
	output word_t dwrite_data,
	output byte_en_t dwrite_en,
	output logic trap
);

	len_t fetch_len;
	branch_t fetch_branch;
	read_mode_t fetch_read_mode;
	alu_op_t exec_op;
	src_a_t exec_src_a;
	src_b_t exec_src_b;
	logic exec_wide;
	reg_idx_t exec_dest;
	byte_en_t exec_reg_en;
	byte_en_t exec_store;
	word_t exec_imm;
	logic exec_trap;
	word_t x, y, z;
	word_t next_x, next_y, next_z;
	flags_t flags, next_flags, alu_flags;
	word_t result;
	reg_idx_t write_idx;
	byte_en_t write_en;
	word_t write_data;

	f8_fetch #(
		.RESET_PC(RESET_PC)
	) fetch (
		.clk(clk),
		.reset(reset),
		.fetch_inst(iread_data),
		.fetch_len(fetch_len),
		.fetch_branch(fetch_branch),
		.fetch_read_mode(fetch_read_mode),
		.next_y(next_y),
		.next_flags(next_flags),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr)
	);

	f8_decode decode (
		.clk(clk),
		.reset(reset),
		.fetch_inst(iread_data),
		.*
	);

	f8_regfile regfile (.*);

	f8_execute execute (.*);

	f8_result result_stage (.*);

endmodule

`default_nettype wire

/* verification/f8_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module f8_core_tb
	import f8_core_pkg::*, f8_isa_pkg::*;
;

	localparam word_t RESET_PC = 16'h4000;
	localparam int SECTIONS = 48;

	localparam opcode_t ALU8_OPS [16] = '{
		OPCODE_LD_XL_IMMD, OPCODE_LD_XL_DIR, OPCODE_ADD_XL_IMMD, OPCODE_ADD_XL_DIR,
		OPCODE_ADC_XL_IMMD, OPCODE_ADC_XL_DIR, OPCODE_SUB_XL_IMMD, OPCODE_SUB_XL_DIR,
		OPCODE_SBC_XL_IMMD, OPCODE_SBC_XL_DIR, OPCODE_AND_XL_IMMD, OPCODE_AND_XL_DIR,
		OPCODE_OR_XL_IMMD, OPCODE_OR_XL_DIR, OPCODE_XOR_XL_IMMD, OPCODE_XOR_XL_DIR
	};
	localparam opcode_t JR_OPS [8] = '{
		OPCODE_JR_D, OPCODE_JRZ_D, OPCODE_JRNZ_D, OPCODE_JRC_D,
		OPCODE_JRNC_D, OPCODE_JRZ_D, OPCODE_JRNZ_D, OPCODE_JRC_D
	};

	logic clk;
	logic reset;
	word_t iread_addr;
	inst_t iread_data;
	word_t dread_addr;
	word_t dread_data;
	word_t dwrite_addr;
	word_t dwrite_data;
	byte_en_t dwrite_en;
	logic trap;

	byte_t rom [0:65535];
	logic [2:0] tag [0:65535];
	byte_t ram [0:65535];
	byte_t mram [0:65535];
	inst_t ird_q;
	word_t drd_q;

	// generator and reference model state
	word_t gpc;
	logic [2:0] cur_tag;
	int n_inst;
	int errors;
	int rst_count;
	word_t mpc, mx, my, mz;
	logic fc, fn, fz, fo;
	byte_en_t pend_en, exp_en;
	word_t pend_daddr, pend_ddata, exp_daddr, exp_ddata, exp_iaddr;
	logic pend_trap, exp_trap;
	logic exp_rd;
	word_t exp_raddr;
	string exp_name;

	f8_core #(
		.RESET_PC(RESET_PC)
	) DUT (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	always #4 clk = ~clk;

	function automatic string section_name(input logic [2:0] t);
		case (t)
			3'd0: return "alu8";
			3'd1: return "word16";
			3'd2: return "branch";
			3'd3: return "forward";
			default: return "trap";
		endcase
	endfunction

	function automatic word_t rand16();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	function automatic word_t data_addr();
		word_t r;
		r = rand16();
		return 16'h0200 + {7'd0, r[8:0]};
	endfunction

	task automatic emit(input byte_t b);
		rom[gpc] = b;
		tag[gpc] = cur_tag;
		gpc = gpc + 16'd1;
	endtask

	task automatic put1(input opcode_t op);
		emit(op);
		n_inst++;
	endtask

	task automatic put2(input opcode_t op, input byte_t b);
		put1(op);
		emit(b);
	endtask

	task automatic put3(input opcode_t op, input word_t w);
		put2(op, w[7:0]);
		emit(w[15:8]);
	endtask

	task automatic skip_bytes(input int k);
		repeat (k)
			put1(OPCODE_NOP);
	endtask

	task automatic build_program();
		word_t r;
		word_t k;
		opcode_t op;
		gpc = RESET_PC;
		cur_tag = 3'd0;
		put2(OPCODE_LD_XL_IMMD, 8'h3c);
		put3(OPCODE_LDW_Y_IMMD, 16'h1234);
		for (int s = 0; s < SECTIONS; s++)
		begin
			r = rand16();
			k = {14'd0, r[9:8]};
			cur_tag = {1'b0, r[1:0]};
			case (r[1:0])
				2'd0:
				begin
					op = ALU8_OPS[r[5:2]];
					if (op[0])
						put3(op, data_addr());
					else
						put2(op, r[15:8]);
					put3(OPCODE_LD_DIR_XL, data_addr());
				end
				2'd1:
				begin
					put3(OPCODE_LDW_Y_IMMD, rand16());
					case (r[3:2])
						2'd0: put3(OPCODE_ADDW_Y_IMMD, rand16());
						2'd1: put1(OPCODE_INCW_Y);
						2'd2:
						begin
							put1(OPCODE_LDW_Z_Y);
							put3(OPCODE_LDW_Y_IMMD, rand16());
							put1(OPCODE_LDW_Y_Z);
						end
						default:
						begin
							put1(OPCODE_LDW_X_Y);
							put3(OPCODE_LD_DIR_XL, data_addr());
						end
					endcase
					put3(OPCODE_LDW_DIR_Y, data_addr());
				end
				2'd2:
				begin
					// arithmetic immediates 10, 18, 20 and 28 set the flags
					put2(8'h10 + {3'd0, r[3:2], 3'b000}, r[15:8]);
					put2(JR_OPS[r[6:4]], k[7:0] + 8'd2);
					skip_bytes(int'(k));
				end
				default:
				begin
					put3(OPCODE_LDW_Y_IMMD, data_addr());
					put1(OPCODE_LD_XL_IY);
					put3(OPCODE_LD_DIR_XL, data_addr());
					put3(OPCODE_LDW_Y_IMMD, gpc + 16'd4 + k);
					put1(OPCODE_JP_Y);
					skip_bytes(int'(k));
					put3(OPCODE_JP_IMMD, gpc + 16'd3 + k);
					skip_bytes(int'(k));
				end
			endcase
		end
		cur_tag = 3'd4;
		put1(OPCODE_TRAP);
		skip_bytes(4);
	endtask

	task automatic set_nz(input logic [15:0] v, input logic wide);
		fn = wide ? v[15] : v[7];
		fz = wide ? (v == 16'h0000) : (v[7:0] == 8'h00);
	endtask

	// one instruction in program order, from the ISA rules
	task automatic step_model();
		opcode_t op;
		word_t imm, npc, v;
		byte_t a, b;
		logic [8:0] s8;
		logic [16:0] s16;
		logic taken;
		op = rom[mpc];
		imm = {rom[mpc + 16'd2], rom[mpc + 16'd1]};
		exp_name = section_name(tag[mpc]);
		pend_en = 2'b00;
		pend_trap = 1'b0;
		exp_rd = 1'b0;
		exp_raddr = imm;
		npc = mpc + 16'd1;
		a = mx[7:0];
		b = op[0] ? mram[imm] : imm[7:0];
		case (op)
			OPCODE_TRAP: pend_trap = 1'b1;
			OPCODE_LD_XL_IMMD, OPCODE_LD_XL_DIR: mx[7:0] = b;
			OPCODE_ADD_XL_IMMD, OPCODE_ADD_XL_DIR, OPCODE_ADC_XL_IMMD, OPCODE_ADC_XL_DIR,
			OPCODE_SUB_XL_IMMD, OPCODE_SUB_XL_DIR, OPCODE_SBC_XL_IMMD, OPCODE_SBC_XL_DIR:
			begin
				if (op[7:4] == 4'h1)
					b = ~b;
				s8 = {1'b0, a} + {1'b0, b} + {8'd0, op[3] ? fc : (op[7:4] == 4'h1)};
				fc = s8[8];
				fo = (a[7] == b[7]) && (s8[7] != a[7]);
				set_nz({8'h00, s8[7:0]}, 1'b0);
				mx[7:0] = s8[7:0];
			end
			OPCODE_AND_XL_IMMD, OPCODE_AND_XL_DIR: mx[7:0] = a & b;
			OPCODE_OR_XL_IMMD, OPCODE_OR_XL_DIR: mx[7:0] = a | b;
			OPCODE_XOR_XL_IMMD, OPCODE_XOR_XL_DIR: mx[7:0] = a ^ b;
			OPCODE_LD_DIR_XL:
			begin
				pend_en = 2'b01;
				pend_daddr = imm;
				pend_ddata = {8'h00, mx[7:0]};
				mram[imm] = mx[7:0];
			end
			OPCODE_LD_XL_IY:
			begin
				mx[7:0] = mram[my];
				exp_rd = 1'b1;
				exp_raddr = my;
			end
			OPCODE_LDW_Y_IMMD: my = imm;
			OPCODE_ADDW_Y_IMMD, OPCODE_INCW_Y:
			begin
				v = (op == OPCODE_INCW_Y) ? 16'h0001 : imm;
				s16 = {1'b0, my} + {1'b0, v};
				fc = s16[16];
				fo = (my[15] == v[15]) && (s16[15] != my[15]);
				set_nz(s16[15:0], 1'b1);
				my = s16[15:0];
			end
			OPCODE_LDW_DIR_Y:
			begin
				pend_en = 2'b11;
				pend_daddr = imm;
				pend_ddata = my;
				mram[imm] = my[7:0];
				mram[imm + 16'd1] = my[15:8];
			end
			OPCODE_LDW_X_Y: mx = my;
			OPCODE_LDW_Z_Y: mz = my;
			OPCODE_LDW_Y_Z: my = mz;
			OPCODE_JP_IMMD: npc = imm;
			OPCODE_JP_Y: npc = my;
			OPCODE_JR_D, OPCODE_JRZ_D, OPCODE_JRNZ_D, OPCODE_JRC_D, OPCODE_JRNC_D:
			begin
				case (op)
					OPCODE_JRZ_D: taken = fz;
					OPCODE_JRNZ_D: taken = !fz;
					OPCODE_JRC_D: taken = fc;
					OPCODE_JRNC_D: taken = !fc;
					default: taken = 1'b1;
				endcase
				npc = taken ? mpc + {{8{imm[7]}}, imm[7:0]} : mpc + 16'd2;
			end
			default: ;
		endcase
		// and/or/xor update n and z only
		if (op[7:4] == 4'h3 || op[7:4] == 4'h4)
			set_nz({8'h00, mx[7:0]}, 1'b0);
		if (op inside {ALU8_OPS})
		begin
			npc = mpc + (op[0] ? 16'd3 : 16'd2);
			exp_rd = op[0];
		end
		if (op inside {OPCODE_LD_DIR_XL, OPCODE_LDW_Y_IMMD, OPCODE_ADDW_Y_IMMD, OPCODE_LDW_DIR_Y})
			npc = mpc + 16'd3;
		mpc = npc;
		exp_iaddr = npc;
	endtask

	task automatic report_mismatch(input string what, input word_t e, input word_t a);
		$display("MISMATCH %s %s expected %h actual %h", exp_name, what, e, a);
		errors++;
	endtask

	task automatic end_run();
		$display("run finished with %0d errors", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	// instruction ROM and write-first data RAM, registered at the rising edge
	always @(posedge clk)
	begin
		if (dwrite_en[0])
			ram[dwrite_addr] = dwrite_data[7:0];
		if (dwrite_en[1])
			ram[dwrite_addr + 16'd1] = dwrite_data[15:8];
		drd_q <= {ram[dread_addr + 16'd1], ram[dread_addr]};
		ird_q <= {rom[iread_addr + 16'd2], rom[iread_addr + 16'd1], rom[iread_addr]};
	end

	always @(negedge clk)
	begin
		iread_data = ird_q;
		dread_data = drd_q;
		if (exp_trap)
			end_run();
		else if (rst_count < 2)
			rst_count++;
		else
		begin
			reset = 1'b0;
			exp_en = pend_en;
			exp_daddr = pend_daddr;
			exp_ddata = pend_ddata;
			exp_trap = pend_trap;
			step_model();
		end
	end

	assert property (@(posedge clk) !reset || iread_addr == RESET_PC)
		else report_mismatch("reset iread_addr", RESET_PC, $sampled(iread_addr));
	assert property (@(posedge clk) !reset || dwrite_en == 2'b00)
		else report_mismatch("reset dwrite_en", 16'h0000, {14'd0, $sampled(dwrite_en)});
	assert property (@(posedge clk) !reset || !trap)
		else report_mismatch("reset trap", 16'h0000, {15'd0, $sampled(trap)});
	assert property (@(posedge clk) reset || iread_addr == exp_iaddr)
		else report_mismatch("iread_addr", exp_iaddr, $sampled(iread_addr));
	assert property (@(posedge clk) reset || !exp_rd || dread_addr == exp_raddr)
		else report_mismatch("dread_addr", exp_raddr, $sampled(dread_addr));
	assert property (@(posedge clk) reset || dwrite_en == exp_en)
		else report_mismatch("dwrite_en", {14'd0, exp_en}, {14'd0, $sampled(dwrite_en)});
	assert property (@(posedge clk) reset || exp_en == 2'b00 || dwrite_addr == exp_daddr)
		else report_mismatch("dwrite_addr", exp_daddr, $sampled(dwrite_addr));
	assert property (@(posedge clk) reset || exp_en == 2'b00 || dwrite_data == exp_ddata)
		else report_mismatch("dwrite_data", exp_ddata, $sampled(dwrite_data));
	assert property (@(posedge clk) reset || trap == exp_trap)
		else report_mismatch("trap", {15'd0, exp_trap}, {15'd0, $sampled(trap)});

	initial
	begin
		void'($urandom(32'ha3cb9c91));
		clk = 1'b0;
		reset = 1'b1;
		iread_data = '0;
		dread_data = '0;
		ird_q = '0;
		drd_q = '0;
		errors = 0;
		n_inst = 0;
		rst_count = 0;
		mpc = RESET_PC;
		{mx, my, mz} = '0;
		{fc, fn, fz, fo} = 4'b0000;
		{pend_en, exp_en, pend_trap, exp_trap, exp_rd} = '0;
		{pend_daddr, pend_ddata, exp_daddr, exp_ddata, exp_iaddr, exp_raddr} = '0;
		exp_name = "reset";
		for (int i = 0; i < 65536; i++)
		begin
			ram[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
			mram[i] = ram[i];
		end
		build_program();
	end

	// watchdog sized from the program length
	initial
	begin
		#1;
		#(n_inst * 4 * 8 + 64);
		$display("timeout: the program never reached its trap");
		errors++;
		end_run();
	end

endmodule

`default_nettype wire

/* project.f */
verilog/f8_isa_pkg.sv
verilog/f8_core_pkg.sv
verilog/f8_decode.sv
verilog/f8_fetch.sv
verilog/f8_regfile.sv
verilog/f8_execute.sv
verilog/f8_result.sv
verilog/f8_core.sv
verification/f8_core_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the f8 core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf build && mkdir -p build
verilator --binary --timing --assert -f project.f --top-module f8_core_tb -Mdir build -o sim \
	&& ./build/sim > build/sim.log 2>&1 ; cat build/sim.log 2>/dev/null
grep -qx "No errors" build/sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
